//--- common/nlc_cfg.svh
`ifndef NLC_CFG_SVH
`define NLC_CFG_SVH

// Channel layout
`define NLC_CHANNELS 16
`define NLC_CAL_WORDS 8

// Raw ADC code width
`define NLC_ADC_W 21

// Fixed point format, signed with 16 fraction bits
`define NLC_DATA_W 32
`define NLC_FRAC 16

// Polynomial order for Horner evaluation
`define NLC_ORDER 5

// Word address into calibration space, channel * 8 + word
`define NLC_WB_ADR_W 7

`endif

//--- common/nlc_pkg.sv
`include "nlc_cfg.svh"

package nlc_pkg;

	typedef logic signed [`NLC_ADC_W-1:0] adc_t; // Raw converter code
	typedef logic signed [`NLC_DATA_W-1:0] fix_t; // 16 fraction bits

	typedef logic [$clog2(`NLC_CHANNELS)-1:0] chan_t;

	// Word index inside one channel's calibration block
	typedef enum logic [$clog2(`NLC_CAL_WORDS)-1:0] {
		CAL_NEG_MEAN = 0,
		CAL_RECIP_STDEV = 1,
		CAL_COEFF_0 = 2,
		CAL_COEFF_1 = 3,
		CAL_COEFF_2 = 4,
		CAL_COEFF_3 = 5,
		CAL_COEFF_4 = 6,
		CAL_COEFF_5 = 7
	} cal_sel_t;

	// Pre add: ((a + c) * b) >>> frac
	// Post add: ((a * b) >>> frac) + c
	typedef enum logic {
		MAC_PRE_ADD,
		MAC_POST_ADD
	} mac_op_t;

endpackage

//--- common/mac_if.sv
`timescale 1ns/1ps

interface mac_if;

	// Request side, one cycle pulse with operands
	logic req;
	nlc_pkg::mac_op_t op;
	nlc_pkg::fix_t a;
	nlc_pkg::fix_t b;
	nlc_pkg::fix_t c;

	// Response, two cycles after req
	logic ack;
	nlc_pkg::fix_t result;

	modport sequencer (
		output req,
		output op,
		output a,
		output b,
		output c,
		input ack,
		input result
	);

	modport mac (
		input req,
		input op,
		input a,
		input b,
		input c,
		output ack,
		output result
	);

endinterface

//--- rtl/cal_regfile.sv
`timescale 1ns/1ps
`include "nlc_cfg.svh"

module cal_regfile (
	input logic clk,
	input logic rst,

	// Wishbone classic slave
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`NLC_WB_ADR_W-1:0] wb_adr,
	input nlc_pkg::fix_t wb_dat_w,
	output nlc_pkg::fix_t wb_dat_r,
	output logic wb_ack,

	// Sequencer read port
	input nlc_pkg::chan_t rd_chan,
	input nlc_pkg::cal_sel_t rd_sel,
	output nlc_pkg::fix_t rd_data
);

	localparam int DEPTH = `NLC_CHANNELS * `NLC_CAL_WORDS;

	nlc_pkg::fix_t mem [DEPTH];

	logic access;
	logic [`NLC_WB_ADR_W-1:0] rd_adr;

	// New cycle seen, ack not yet given
	assign access = wb_cyc & wb_stb & ~wb_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= access; // Single cycle ack
		end
	end

	// Calibration words come up as zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (access && wb_we) begin
			mem[wb_adr] <= wb_dat_w;
		end
	end

	// Read data lines up with ack
	always_ff @(posedge clk) begin
		if (access) begin
			wb_dat_r <= mem[wb_adr];
		end
	end

	assign rd_adr = {rd_chan, rd_sel};
	assign rd_data = mem[rd_adr]; // Same cycle lookup

endmodule

//--- nlc_core/nlc_mac.sv
`timescale 1ns/1ps
`include "nlc_cfg.svh"

module nlc_mac (
	input logic clk,
	input logic rst,
	mac_if.mac mac
);

	localparam int PROD_W = 2 * `NLC_DATA_W;

	// Stage one registers
	logic s1_valid;
	nlc_pkg::fix_t mul_a;
	nlc_pkg::fix_t mul_b;
	nlc_pkg::fix_t add_c;

	logic signed [PROD_W-1:0] product;
	logic signed [PROD_W-1:0] scaled;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= mac.req;
		end
	end

	always_ff @(posedge clk) begin
		if (mac.req) begin
			mul_b <= mac.b;
			if (mac.op == nlc_pkg::MAC_PRE_ADD) begin
				mul_a <= mac.a + mac.c; // Offset before scaling
				add_c <= '0;
			end else begin
				mul_a <= mac.a;
				add_c <= mac.c;
			end
		end
	end

	// Full width product, then drop fraction bits
	assign product = PROD_W'(mul_a) * PROD_W'(mul_b);
	assign scaled = product >>> `NLC_FRAC;

	always_ff @(posedge clk) begin
		if (rst) begin
			mac.ack <= 1'b0;
		end else begin
			mac.ack <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			mac.result <= scaled[`NLC_DATA_W-1:0] + add_c; // Wraps mod 2^32
		end
	end

endmodule

//--- nlc_core/nlc_sequencer.sv
`timescale 1ns/1ps
`include "nlc_cfg.svh"

module nlc_sequencer (
	input logic clk,
	input logic rst,

	// Sample stream in
	input logic adc_valid,
	output logic adc_ready,
	input nlc_pkg::adc_t adc_data,

	// Result stream out
	output logic lin_valid,
	input logic lin_ready,
	output nlc_pkg::chan_t lin_chan,
	output nlc_pkg::fix_t lin_data,

	// Calibration lookup
	output nlc_pkg::chan_t rd_chan,
	output nlc_pkg::cal_sel_t rd_sel,
	input nlc_pkg::fix_t rd_data,

	mac_if.sequencer mac
);

	localparam int SEL_W = $bits(nlc_pkg::cal_sel_t);
	localparam nlc_pkg::chan_t CHAN_LAST = nlc_pkg::chan_t'(`NLC_CHANNELS - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_NORM,
		S_NORM_WAIT,
		S_STEP,
		S_STEP_WAIT,
		S_OUT
	} state_t;

	state_t state;

	nlc_pkg::chan_t chan_cnt; // Channel of the next sample
	nlc_pkg::chan_t chan_cur;

	logic [SEL_W-1:0] k; // Coefficient index for Horner
	logic [SEL_W-1:0] step_sel;

	nlc_pkg::fix_t x_fix;
	nlc_pkg::fix_t x_r;
	nlc_pkg::fix_t mean_r;
	nlc_pkg::fix_t t_r; // Normalized input
	nlc_pkg::fix_t acc;

	logic accept;
	logic norm_done;
	logic step_done;

	assign adc_ready = (state == S_IDLE);
	assign accept = adc_valid & adc_ready;
	assign norm_done = (state == S_NORM_WAIT) && mac.ack;
	assign step_done = (state == S_STEP_WAIT) && mac.ack;

	// Integer code to fixed point
	assign x_fix = nlc_pkg::fix_t'(adc_data) <<< `NLC_FRAC;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			chan_cnt <= '0;
			k <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (accept) begin
						state <= S_NORM;
						chan_cnt <= (chan_cnt == CHAN_LAST) ? '0 : chan_cnt + 1'b1;
					end
				end
				S_NORM: state <= S_NORM_WAIT;
				S_NORM_WAIT: begin
					if (mac.ack) begin
						state <= S_STEP;
						k <= SEL_W'(`NLC_ORDER - 1); // acc already holds top coeff
					end
				end
				S_STEP: state <= S_STEP_WAIT;
				S_STEP_WAIT: begin
					if (mac.ack) begin
						if (k == '0) begin
							state <= S_OUT;
						end else begin
							k <= k - 1'b1;
							state <= S_STEP;
						end
					end
				end
				S_OUT: begin
					if (lin_ready) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			x_r <= x_fix;
			mean_r <= rd_data; // Neg mean is on the read port while idle
			chan_cur <= chan_cnt;
		end
		if (norm_done) begin
			t_r <= mac.result;
			acc <= rd_data; // Coeff 5 seed
		end
		if (step_done) begin
			acc <= mac.result;
		end
	end

	assign step_sel = SEL_W'(nlc_pkg::CAL_COEFF_0) + k;

	always_comb begin
		rd_chan = chan_cur;
		case (state)
			S_IDLE: begin
				rd_chan = chan_cnt;
				rd_sel = nlc_pkg::CAL_NEG_MEAN;
			end
			S_NORM: rd_sel = nlc_pkg::CAL_RECIP_STDEV;
			S_NORM_WAIT: rd_sel = nlc_pkg::CAL_COEFF_5;
			default: rd_sel = nlc_pkg::cal_sel_t'(step_sel);
		endcase
	end

	// Normalize uses pre add, every Horner step post add
	assign mac.req = (state == S_NORM) || (state == S_STEP);
	assign mac.op = (state == S_NORM) ? nlc_pkg::MAC_PRE_ADD : nlc_pkg::MAC_POST_ADD;
	assign mac.a = (state == S_NORM) ? x_r : acc;
	assign mac.b = (state == S_NORM) ? rd_data : t_r;
	assign mac.c = (state == S_NORM) ? mean_r : rd_data;

	// Held until taken
	assign lin_valid = (state == S_OUT);
	assign lin_chan = chan_cur;
	assign lin_data = acc;

endmodule

//--- rtl/nlc_top.sv
`timescale 1ns/1ps
`include "nlc_cfg.svh"

module nlc_top (
	input logic clk,
	input logic rst,

	// Host access to calibration words
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [`NLC_WB_ADR_W-1:0] wb_adr,
	input nlc_pkg::fix_t wb_dat_w,
	output nlc_pkg::fix_t wb_dat_r,
	output logic wb_ack,

	// Raw samples, channel order 0 to 15
	input logic adc_valid,
	output logic adc_ready,
	input nlc_pkg::adc_t adc_data,

	// Linearized results
	output logic lin_valid,
	input logic lin_ready,
	output nlc_pkg::chan_t lin_chan,
	output nlc_pkg::fix_t lin_data
);

	nlc_pkg::chan_t rd_chan;
	nlc_pkg::cal_sel_t rd_sel;
	nlc_pkg::fix_t rd_data;

	mac_if mac_bus ();

	cal_regfile u_cal_regfile (
		.clk (clk),
		.rst (rst),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we (wb_we),
		.wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.rd_chan (rd_chan),
		.rd_sel (rd_sel),
		.rd_data (rd_data)
	);

	nlc_sequencer u_sequencer (
		.clk (clk),
		.rst (rst),
		.adc_valid (adc_valid),
		.adc_ready (adc_ready),
		.adc_data (adc_data),
		.lin_valid (lin_valid),
		.lin_ready (lin_ready),
		.lin_chan (lin_chan),
		.lin_data (lin_data),
		.rd_chan (rd_chan),
		.rd_sel (rd_sel),
		.rd_data (rd_data),
		.mac (mac_bus.sequencer)
	);

	// Shared by normalize and all Horner steps
	nlc_mac u_mac (
		.clk (clk),
		.rst (rst),
		.mac (mac_bus.mac)
	);

endmodule

//--- sim/tb_nlc.sv
`timescale 1ns/1ps
`include "nlc_cfg.svh"

module tb_nlc;

	localparam int CLK_PERIOD = 40;
	localparam int CAL_DEPTH = `NLC_CHANNELS * `NLC_CAL_WORDS;
	localparam nlc_pkg::fix_t FIX_ONE = 32'sd1 <<< `NLC_FRAC;
	// Rough sum of all test phases including bus accesses and samples
	localparam int TEST_CYCLES = 3600;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`NLC_WB_ADR_W-1:0] wb_adr;
	nlc_pkg::fix_t wb_dat_w;
	nlc_pkg::fix_t wb_dat_r;
	logic wb_ack;
	logic adc_valid;
	logic adc_ready;
	nlc_pkg::adc_t adc_data;
	logic lin_valid;
	logic lin_ready;
	nlc_pkg::chan_t lin_chan;
	nlc_pkg::fix_t lin_data;

	nlc_pkg::fix_t cal_mem [CAL_DEPTH]; // Mirror of the calibration words
	int exp_chan; // Channel the next sample should land on
	int errors;
	int checks;
	int unsigned seed_val;

	nlc_top DUT (
		.clk (clk),
		.rst (rst),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we (wb_we),
		.wb_adr (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack (wb_ack),
		.adc_valid (adc_valid),
		.adc_ready (adc_ready),
		.adc_data (adc_data),
		.lin_valid (lin_valid),
		.lin_ready (lin_ready),
		.lin_chan (lin_chan),
		.lin_data (lin_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check(input string name, input logic signed [63:0] expected,
			input logic signed [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error at %0t ns: %s expected %0d, actual %0d", $time, name,
				expected, actual);
		end
	endtask

	function automatic longint rand_signed(input int bits);
		return longint'($urandom_range((1 << bits) - 1, 0)) - (longint'(1) << (bits - 1));
	endfunction

	function automatic nlc_pkg::fix_t to_fix(input longint v);
		return nlc_pkg::fix_t'(v); // Keep low 32 bits
	endfunction

	function automatic nlc_pkg::fix_t code_to_fix(input nlc_pkg::adc_t x);
		return to_fix(longint'(x) <<< `NLC_FRAC);
	endfunction

	// ((a + c) * b) >>> 16
	function automatic nlc_pkg::fix_t pre_add(input nlc_pkg::fix_t a, input nlc_pkg::fix_t b,
			input nlc_pkg::fix_t c);
		longint s;
		s = longint'(a) + longint'(c);
		return to_fix((s * longint'(b)) >>> `NLC_FRAC);
	endfunction

	// ((a * b) >>> 16) + c, mod 2^32
	function automatic nlc_pkg::fix_t post_add(input nlc_pkg::fix_t a, input nlc_pkg::fix_t b,
			input nlc_pkg::fix_t c);
		longint p;
		p = (longint'(a) * longint'(b)) >>> `NLC_FRAC;
		return to_fix(p + longint'(c));
	endfunction

	function automatic int cal_addr(input int chan, input int sel);
		return chan * `NLC_CAL_WORDS + sel;
	endfunction

	function automatic nlc_pkg::fix_t model_result(input int chan, input nlc_pkg::adc_t x);
		nlc_pkg::fix_t t;
		nlc_pkg::fix_t acc;
		t = pre_add(code_to_fix(x), cal_mem[cal_addr(chan, nlc_pkg::CAL_RECIP_STDEV)],
			cal_mem[cal_addr(chan, nlc_pkg::CAL_NEG_MEAN)]);
		acc = cal_mem[cal_addr(chan, nlc_pkg::CAL_COEFF_5)];
		for (int k = `NLC_ORDER - 1; k >= 0; k--) begin
			acc = post_add(acc, t, cal_mem[cal_addr(chan, int'(nlc_pkg::CAL_COEFF_0) + k)]);
		end
		return acc;
	endfunction

	task automatic wb_access(input logic we, input int adr, input nlc_pkg::fix_t wdata,
			output nlc_pkg::fix_t rdata);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		@(negedge clk);
		while (!wb_ack) @(negedge clk);
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
		check("wb_ack", 0, wb_ack); // Must drop after one cycle
	endtask

	task automatic write_cal(input int adr, input nlc_pkg::fix_t data);
		nlc_pkg::fix_t unused;
		wb_access(1'b1, adr, data, unused);
		cal_mem[adr] = data;
	endtask

	task automatic read_cal(input int adr, output nlc_pkg::fix_t data);
		wb_access(1'b0, adr, '0, data);
	endtask

	task automatic send_sample(input nlc_pkg::adc_t x);
		@(negedge clk);
		adc_data = x;
		adc_valid = 1'b1;
		while (!adc_ready) @(negedge clk);
		@(negedge clk); // Taken on the edge in between
		adc_valid = 1'b0;
	endtask

	task automatic receive_result(output nlc_pkg::chan_t chan, output nlc_pkg::fix_t data);
		@(negedge clk);
		lin_ready = 1'b1;
		while (!lin_valid) @(negedge clk);
		chan = lin_chan;
		data = lin_data;
		@(negedge clk);
		lin_ready = 1'b0;
	endtask

	task automatic run_sample(input nlc_pkg::adc_t x, input nlc_pkg::fix_t expected);
		nlc_pkg::chan_t chan;
		nlc_pkg::fix_t data;
		send_sample(x);
		receive_result(chan, data);
		check("lin_chan", exp_chan, chan);
		check("lin_data", expected, data);
		exp_chan = (exp_chan + 1) % `NLC_CHANNELS;
	endtask

	task automatic test_reset_state;
		nlc_pkg::fix_t data;
		@(negedge clk);
		check("adc_ready", 1, adc_ready);
		check("lin_valid", 0, lin_valid);
		for (int i = 0; i < CAL_DEPTH; i++) begin
			read_cal(i, data);
			check("wb_dat_r", 0, data);
		end
	endtask

	task automatic test_regfile_rw;
		nlc_pkg::fix_t data;
		for (int i = 0; i < CAL_DEPTH; i++) begin
			write_cal(i, nlc_pkg::fix_t'($urandom));
		end
		for (int i = 0; i < CAL_DEPTH; i++) begin
			read_cal(i, data);
			check("wb_dat_r", cal_mem[i], data);
		end
	endtask

	task automatic test_identity;
		nlc_pkg::adc_t x;
		for (int ch = 0; ch < `NLC_CHANNELS; ch++) begin
			for (int sel = 0; sel < `NLC_CAL_WORDS; sel++) begin
				if (sel == nlc_pkg::CAL_RECIP_STDEV || sel == nlc_pkg::CAL_COEFF_1)
					write_cal(cal_addr(ch, sel), FIX_ONE);
				else
					write_cal(cal_addr(ch, sel), '0);
			end
		end
		for (int i = 0; i < `NLC_CHANNELS; i++) begin
			x = nlc_pkg::adc_t'(rand_signed(`NLC_ADC_W));
			run_sample(x, code_to_fix(x)); // Output is just x_fix
		end
	endtask

	task automatic load_random_cal;
		for (int ch = 0; ch < `NLC_CHANNELS; ch++) begin
			write_cal(cal_addr(ch, nlc_pkg::CAL_NEG_MEAN), to_fix(rand_signed(21)));
			write_cal(cal_addr(ch, nlc_pkg::CAL_RECIP_STDEV),
				to_fix($urandom_range((1 << 17) - 1, 1)));
			for (int k = 0; k <= `NLC_ORDER; k++) begin
				write_cal(cal_addr(ch, int'(nlc_pkg::CAL_COEFF_0) + k), to_fix(rand_signed(18)));
			end
		end
	endtask

	task automatic test_random_frames;
		nlc_pkg::adc_t x;
		load_random_cal();
		for (int i = 0; i < 2 * `NLC_CHANNELS; i++) begin
			x = nlc_pkg::adc_t'(rand_signed(12));
			run_sample(x, model_result(exp_chan, x));
		end
	endtask

	task automatic test_backpressure;
		nlc_pkg::adc_t x0;
		nlc_pkg::adc_t x1;
		nlc_pkg::fix_t held_data;
		nlc_pkg::chan_t held_chan;
		int hold;
		for (int round = 0; round < 3; round++) begin
			x0 = nlc_pkg::adc_t'(rand_signed(12));
			x1 = nlc_pkg::adc_t'(rand_signed(12));
			send_sample(x0);
			while (!lin_valid) @(negedge clk);
			held_data = lin_data;
			held_chan = lin_chan;
			check("lin_chan", exp_chan, held_chan);
			check("lin_data", model_result(exp_chan, x0), held_data);
			exp_chan = (exp_chan + 1) % `NLC_CHANNELS;
			adc_data = x1; // Offered while the output is stalled
			adc_valid = 1'b1;
			hold = $urandom_range(12, 3);
			repeat (hold) begin
				@(negedge clk);
				check("lin_valid", 1, lin_valid);
				check("lin_data", held_data, lin_data);
				check("lin_chan", held_chan, lin_chan);
				check("adc_ready", 0, adc_ready);
			end
			lin_ready = 1'b1;
			@(negedge clk);
			lin_ready = 1'b0;
			check("lin_valid", 0, lin_valid);
			check("adc_ready", 1, adc_ready);
			@(negedge clk);
			adc_valid = 1'b0;
			check("adc_ready", 0, adc_ready); // x1 now in flight
			receive_result(held_chan, held_data);
			check("lin_chan", exp_chan, held_chan);
			check("lin_data", model_result(exp_chan, x1), held_data);
			exp_chan = (exp_chan + 1) % `NLC_CHANNELS;
		end
	endtask

	initial begin
		#(TEST_CYCLES * 4 * CLK_PERIOD);
		$display("Timeout: tests did not complete within %0d ns, %0d errors so far",
			TEST_CYCLES * 4 * CLK_PERIOD, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		adc_valid = 1'b0;
		adc_data = '0;
		lin_ready = 1'b0;
		exp_chan = 0;
		errors = 0;
		checks = 0;
		seed_val = $urandom(32'hca6e89c0);
		for (int i = 0; i < CAL_DEPTH; i++) begin
			cal_mem[i] = '0;
		end
		repeat (16) @(negedge clk);
		rst = 1'b0;

		test_reset_state();
		test_regfile_rw();
		test_identity();
		test_random_frames();
		test_backpressure();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+common
common/nlc_pkg.sv
common/mac_if.sv
rtl/cal_regfile.sv
nlc_core/nlc_mac.sv
nlc_core/nlc_sequencer.sv
rtl/nlc_top.sv
sim/tb_nlc.sv
